//--- design/lc_bfm_cfg.svh
/*
  Lifecycle controller stand-in configuration
  Trigger and status addresses, read window, reset sequencing depths
*/
`ifndef LC_BFM_CFG_SVH
`define LC_BFM_CFG_SVH

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
// Status word, read only
`define LC_BFM_STATUS_ADDR 32'h7000_0440
// Read side effect requests a delayed system reset
`define LC_BFM_PWR_ADDR    32'h7000_0444
// Read side effect toggles the RMA-on-PPD strap
`define LC_BFM_RMA_ADDR    32'h7000_0448
// Decoded window of the stand-in, 256 bytes
`define LC_BFM_BASE        32'h7000_0400
`define LC_BFM_SIZE        32'h0000_0100

// ---------------------------------------------------------------------------
// Reset sequencing
// ---------------------------------------------------------------------------
// Stages between the power-cycle pulse and the hold counter
`define LC_BFM_DELAY       20
// Hold count, also sets the length of the low reset period
`define LC_BFM_HOLD        500

`endif

//--- design/axi_rd_pkg.sv
/*
  AXI read channel types
  Request and response bundles for a single-beat read slave, response codes
*/
package axi_rd_pkg;

    // Response codes used by the read target
    // Only OKAY and DECERR are produced
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } resp_e;

    // Host to slave, AR channel plus R ready
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axi_rd_req_t;

    // Slave to host, AR ready plus the R beat
    typedef struct packed {
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        resp_e       rresp;
    } axi_rd_rsp_t;

    // No ID, burst or last fields
    // Every read is one beat

endpackage

//--- design/lc_bfm_pkg.sv
/*
  Lifecycle stand-in types
  Multi-bit lifecycle signal, accepted-read event, status word layout
*/
package lc_bfm_pkg;

    // Multi-bit encoded on/off, as used on lifecycle broadcast signals
    // Any other pattern is not On
    typedef enum logic [3:0] {
        On  = 4'b0101,
        Off = 4'b1010
    } lc_tx_t;

    // One accepted AR handshake
    // fire is high only in the handshake cycle
    typedef struct packed {
        logic        fire;
        logic [31:0] addr;
    } ar_evt_t;

    // ---------------------------------------------------------------------
    // Status word returned at the status address
    // ---------------------------------------------------------------------
    // First field is the MSB end of the packed word
    typedef struct packed {
        logic [28:0] rsvd;
        // Delay line occupied or hold counter still running
        logic        pwr_busy;
        // Current system reset level
        logic        sys_reset_n;
        // Current RMA-on-PPD strap
        logic        rma_strap;
    } lc_status_t;

endpackage

//--- design/axi_rd_target.sv
/*
  AXI read target for the lifecycle stand-in
  Single outstanding read, status word or zero data, DECERR outside window
*/
`timescale 1ns/1ps
`include "lc_bfm_cfg.svh"

module axi_rd_target (
    input  logic                     clk,
    input  logic                     reset_n,
    input  axi_rd_pkg::axi_rd_req_t  req,
    input  lc_bfm_pkg::lc_status_t   status,
    output axi_rd_pkg::axi_rd_rsp_t  rsp,
    output lc_bfm_pkg::ar_evt_t      ar_evt
);

    // R channel state
    logic              rvalid_q;
    logic [31:0]       rdata_q;
    axi_rd_pkg::resp_e rresp_q;

    // Handshake terms
    logic arready;
    logic ar_hs;
    logic r_hs;

    // Address decode
    logic in_window;
    logic is_status;

    // ---------------------------------------------------------------------
    // Handshakes
    // ---------------------------------------------------------------------
    // Free slot, or the pending beat leaves this cycle
    assign arready = !rvalid_q || req.rready;
    assign ar_hs   = req.arvalid && arready;
    assign r_hs    = rvalid_q && req.rready;

    // Decode on the live AR address
    assign in_window = (req.araddr >= `LC_BFM_BASE) &&
                       (req.araddr < (`LC_BFM_BASE + `LC_BFM_SIZE));
    assign is_status = (req.araddr == `LC_BFM_STATUS_ADDR);

    // Valid flag is the only control state here
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;
        end else if (r_hs) begin
            rvalid_q <= 1'b0;
        end
    end

    // Beat payload captured at AR acceptance
    // Held until the host takes it
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= is_status ? status : 32'h0;
            rresp_q <= in_window ? axi_rd_pkg::OKAY : axi_rd_pkg::DECERR;
        end
    end

    // ---------------------------------------------------------------------
    // Outputs
    // ---------------------------------------------------------------------
    assign rsp.arready = arready;
    assign rsp.rvalid  = rvalid_q;
    assign rsp.rdata   = rdata_q;
    assign rsp.rresp   = rresp_q;

    // Event for the trigger decoder, same cycle as the handshake
    assign ar_evt.fire = ar_hs;
    assign ar_evt.addr = req.araddr;

endmodule

//--- design/lc_trigger_decode.sv
/*
  Trigger decoder
  Power-cycle pulse and RMA strap toggle from accepted reads
*/
`timescale 1ns/1ps
`include "lc_bfm_cfg.svh"

module lc_trigger_decode (
    input  logic                 clk,
    input  logic                 reset_n,
    input  lc_bfm_pkg::ar_evt_t  ar_evt,
    output logic                 pwr_req,
    output logic                 rma_strap
);

    // Accepted read hits
    logic pwr_hit;
    logic rma_hit;

    assign pwr_hit = ar_evt.fire && (ar_evt.addr == `LC_BFM_PWR_ADDR);
    assign rma_hit = ar_evt.fire && (ar_evt.addr == `LC_BFM_RMA_ADDR);

    // Single-cycle pulse
    // Back-to-back hits collapse into one pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pwr_req <= 1'b0;
        end else begin
            pwr_req <= pwr_hit && !pwr_req;
        end
    end

    // Strap flip-flop
    // Toggle blocked while a power-cycle pulse is out
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rma_strap <= 1'b0;
        end else if (rma_hit && !pwr_req) begin
            rma_strap <= ~rma_strap;
        end
    end

endmodule

//--- design/lc_power_seq.sv
/*
  Power sequencer
  Delays power-cycle pulses, then runs the hold counter for sys_reset_n
*/
`timescale 1ns/1ps
`include "lc_bfm_cfg.svh"

module lc_power_seq (
    input  logic clk,
    input  logic reset_n,
    input  logic pwr_req,
    output logic sys_reset_n,
    output logic pwr_busy
);

    localparam int CNT_W = $clog2(`LC_BFM_HOLD + 1);
    localparam logic [CNT_W-1:0] HOLD_CNT = CNT_W'(`LC_BFM_HOLD);

    // Delay line plus its output stage
    logic [`LC_BFM_DELAY-1:0] dly_q;
    logic                     dly_out_q;

    // Hold counter
    logic [CNT_W-1:0] cnt_q;
    logic             holding;

    assign holding = (cnt_q < HOLD_CNT);

    // ---------------------------------------------------------------------
    // Delay line
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_q     <= '0;
            dly_out_q <= 1'b0;
        end else begin
            dly_q     <= {dly_q[`LC_BFM_DELAY-2:0], pwr_req};
            dly_out_q <= dly_q[`LC_BFM_DELAY-1];
        end
    end

    // ---------------------------------------------------------------------
    // Hold counter and reset level
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q       <= '0;
            sys_reset_n <= 1'b1;
        end else if (holding) begin
            // Level frozen, delayed pulses dropped
            cnt_q <= cnt_q + 1'b1;
        end else if (dly_out_q) begin
            // Taken, start a new low period
            cnt_q       <= '0;
            sys_reset_n <= 1'b0;
        end else begin
            sys_reset_n <= 1'b1;
        end
    end

    // Anything still in flight counts as busy
    assign pwr_busy = (|dly_q) || dly_out_q || holding;

endmodule

//--- design/lc_clk_byp_resp.sv
/*
  Clock bypass responder
  One-cycle On acknowledge for the clock manager bypass request
*/
`timescale 1ns/1ps

module lc_clk_byp_resp (
    input  logic                clk,
    input  logic                reset_n,
    input  lc_bfm_pkg::lc_tx_t  clk_byp_req,
    output lc_bfm_pkg::lc_tx_t  clk_byp_ack
);

    // Strict On compare, other encodings count as Off
    logic req_on;

    assign req_on = (clk_byp_req == lc_bfm_pkg::On);

    // Ack alternates On/Off while the request holds On
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            clk_byp_ack <= lc_bfm_pkg::Off;
        end else if (req_on && (clk_byp_ack == lc_bfm_pkg::Off)) begin
            clk_byp_ack <= lc_bfm_pkg::On;
        end else begin
            clk_byp_ack <= lc_bfm_pkg::Off;
        end
    end

endmodule

//--- design/lc_ctrl_bfm.sv
/*
  Lifecycle controller stand-in, top level
  AXI read slave with power-cycle and RMA side effects, clock bypass ack
*/
`timescale 1ns/1ps

module lc_ctrl_bfm (
    input  logic                     clk,
    input  logic                     reset_n,
    input  axi_rd_pkg::axi_rd_req_t  axi_req,
    output axi_rd_pkg::axi_rd_rsp_t  axi_rsp,
    output logic                     rma_strap,
    output logic                     sys_reset_n,
    input  lc_bfm_pkg::lc_tx_t       clk_byp_req,
    output lc_bfm_pkg::lc_tx_t       clk_byp_ack
);

    lc_bfm_pkg::ar_evt_t    ar_evt;
    lc_bfm_pkg::lc_status_t status;
    logic                   pwr_req;
    logic                   pwr_busy;

    // Status word from live block outputs
    assign status = '{rsvd: '0, pwr_busy: pwr_busy, sys_reset_n: sys_reset_n,
                      rma_strap: rma_strap};

    // ---------------------------------------------------------------------
    // Read path and side effects
    // ---------------------------------------------------------------------
    axi_rd_target u_rd_target (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (axi_req),
        .status  (status),
        .rsp     (axi_rsp),
        .ar_evt  (ar_evt)
    );

    lc_trigger_decode u_trig (
        .clk       (clk),
        .reset_n   (reset_n),
        .ar_evt    (ar_evt),
        .pwr_req   (pwr_req),
        .rma_strap (rma_strap)
    );

    lc_power_seq u_pwr_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .pwr_req     (pwr_req),
        .sys_reset_n (sys_reset_n),
        .pwr_busy    (pwr_busy)
    );

    // Clock manager side
    lc_clk_byp_resp u_clk_byp (
        .clk         (clk),
        .reset_n     (reset_n),
        .clk_byp_req (clk_byp_req),
        .clk_byp_ack (clk_byp_ack)
    );

endmodule

//--- dv/lc_ctrl_bfm_tb.sv
/*
  Testbench for the lifecycle controller stand-in
  Seeded random AXI reads and bypass requests checked against a cycle model
*/
`timescale 1ns/1ps
`include "lc_bfm_cfg.svh"

module lc_ctrl_bfm_tb;

    logic                    clk;
    logic                    reset_n;
    axi_rd_pkg::axi_rd_req_t axi_req;
    axi_rd_pkg::axi_rd_rsp_t axi_rsp;
    logic                    rma_strap;
    logic                    sys_reset_n;
    lc_bfm_pkg::lc_tx_t      clk_byp_req;
    lc_bfm_pkg::lc_tx_t      clk_byp_ack;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     err_mark;
    int     n;
    int     lows;
    logic   ar_seen;
    logic   rma_start;

    // Cycle model of the state after the most recent rising edge
    axi_rd_pkg::axi_rd_rsp_t m_rsp;
    logic                    m_st_rd;
    logic                    m_pwr_req;
    logic                    m_rma;
    // Delay stages with the output stage as the top bit
    logic [`LC_BFM_DELAY:0]  m_dly;
    int                      m_cnt;
    logic                    m_sys;
    lc_bfm_pkg::lc_tx_t      m_ack;

    lc_ctrl_bfm dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .axi_req     (axi_req),
        .axi_rsp     (axi_rsp),
        .rma_strap   (rma_strap),
        .sys_reset_n (sys_reset_n),
        .clk_byp_req (clk_byp_req),
        .clk_byp_ack (clk_byp_ack)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_rsp(input axi_rd_pkg::axi_rd_rsp_t got,
                             input axi_rd_pkg::axi_rd_rsp_t exp);
        checks++;
        if (got.arready !== exp.arready || got.rvalid !== exp.rvalid ||
            (exp.rvalid && (got.rdata !== exp.rdata || got.rresp !== exp.rresp))) begin
            errors++;
            $display("FAIL %0t: rsp got ar=%b rv=%b %h/%0d, exp ar=%b rv=%b %h/%0d", $time,
                     got.arready, got.rvalid, got.rdata, got.rresp,
                     exp.arready, exp.rvalid, exp.rdata, exp.rresp);
        end
    endtask

    task automatic check_status(input lc_bfm_pkg::lc_status_t got,
                                input lc_bfm_pkg::lc_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: status word got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ack(input lc_bfm_pkg::lc_tx_t got, input lc_bfm_pkg::lc_tx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: clk_byp_ack got %b, expected %b", $time, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Cycle model
    // ------------------------------------------------------------------------
    task automatic reset_model();
        m_rsp     = '{arready: 1'b1, rvalid: 1'b0, rdata: 32'h0, rresp: axi_rd_pkg::OKAY};
        m_st_rd   = 1'b0;
        m_pwr_req = 1'b0;
        m_rma     = 1'b0;
        m_dly     = '0;
        m_cnt     = 0;
        m_sys     = 1'b1;
        m_ack     = lc_bfm_pkg::Off;
    endtask

    // Runs mid-cycle where inputs and outputs have settled
    task automatic sample_and_advance();
        logic                   hs_r;
        logic                   in_win;
        logic [31:0]            a;
        lc_bfm_pkg::lc_status_t st;
        a = axi_req.araddr;
        m_rsp.arready = !m_rsp.rvalid || axi_req.rready;
        check_rsp(axi_rsp, m_rsp);
        check_level(rma_strap, m_rma, "rma_strap");
        check_level(sys_reset_n, m_sys, "sys_reset_n");
        check_ack(clk_byp_ack, m_ack);
        st = '{rsvd: '0, pwr_busy: (|m_dly) || (m_cnt < `LC_BFM_HOLD),
               sys_reset_n: m_sys, rma_strap: m_rma};
        // Handshakes as seen on the ports
        ar_seen = axi_req.arvalid && axi_rsp.arready;
        hs_r    = axi_rsp.rvalid && axi_req.rready;
        in_win  = (a >= `LC_BFM_BASE) && (a < `LC_BFM_BASE + `LC_BFM_SIZE);
        if (hs_r && m_st_rd) begin
            check_status(lc_bfm_pkg::lc_status_t'(axi_rsp.rdata),
                         lc_bfm_pkg::lc_status_t'(m_rsp.rdata));
        end
        // RMA toggle gated by a pulse already out
        if (ar_seen && a == `LC_BFM_RMA_ADDR && !m_pwr_req) begin
            m_rma = !m_rma;
        end
        // Hold window takes priority over a landing pulse
        if (m_cnt < `LC_BFM_HOLD) begin
            m_cnt++;
        end else if (m_dly[`LC_BFM_DELAY]) begin
            m_cnt = 0;
            m_sys = 1'b0;
        end else begin
            m_sys = 1'b1;
        end
        m_dly     = {m_dly[`LC_BFM_DELAY-1:0], m_pwr_req};
        m_pwr_req = ar_seen && (a == `LC_BFM_PWR_ADDR) && !m_pwr_req;
        m_ack     = (clk_byp_req == lc_bfm_pkg::On && m_ack == lc_bfm_pkg::Off) ?
                    lc_bfm_pkg::On : lc_bfm_pkg::Off;
        // Single R slot
        if (ar_seen) begin
            m_rsp.rvalid = 1'b1;
            m_st_rd      = (a == `LC_BFM_STATUS_ADDR);
            m_rsp.rdata  = m_st_rd ? 32'(st) : 32'h0;
            m_rsp.rresp  = in_win ? axi_rd_pkg::OKAY : axi_rd_pkg::DECERR;
        end else if (hs_r) begin
            m_rsp.rvalid = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic drive(input logic av, input logic [31:0] addr, input logic rr,
                         input lc_bfm_pkg::lc_tx_t byp);
        @(posedge clk);
        axi_req     <= '{arvalid: av, araddr: addr, rready: rr};
        clk_byp_req <= byp;
        @(negedge clk);
        sample_and_advance();
    endtask

    // Holds arvalid until the address is taken
    task automatic issue_read(input logic [31:0] addr);
        int tries;
        tries   = 0;
        ar_seen = 1'b0;
        while (!ar_seen && tries < 16) begin
            drive(1'b1, addr, 1'b1, lc_bfm_pkg::Off);
            tries++;
        end
        if (!ar_seen) begin
            errors++;
            $display("timeout: read of %h never accepted", addr);
        end
    endtask

    // Status, power, RMA, in-window other, out of window
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        case (int'(r[18:16]) % 5)
            0:       pick_addr = `LC_BFM_STATUS_ADDR;
            1:       pick_addr = `LC_BFM_PWR_ADDR;
            2:       pick_addr = `LC_BFM_RMA_ADDR;
            3:       pick_addr = `LC_BFM_BASE + 32'h80 + 32'({r[30:26], 2'b00});
            default: pick_addr = 32'h6000_0000 + 32'({r[30:26], 2'b00});
        endcase
    endfunction

    task automatic random_cycle(input logic reads);
        logic [31:0]        r;
        lc_bfm_pkg::lc_tx_t byp;
        r = $random(seed);
        case (r[21:20])
            2'd0, 2'd1: byp = lc_bfm_pkg::On;
            2'd2:       byp = lc_bfm_pkg::Off;
            default:    byp = lc_bfm_pkg::lc_tx_t'(4'b0110);
        endcase
        // rready high three times in four
        drive(reads && r[0], pick_addr(r), r[1] | r[2], byp);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %-10s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        seed         = 73;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        ar_seen      = 1'b0;
        reset_n      = 1'b0;
        axi_req      = '0;
        clk_byp_req  = lc_bfm_pkg::Off;
        reset_model();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_ack(clk_byp_ack, lc_bfm_pkg::Off);
        sample_and_advance();
        end_test("reset");

        // Back-to-back power reads inside the hold window
        issue_read(`LC_BFM_PWR_ADDR);
        issue_read(`LC_BFM_PWR_ADDR);
        // RMA read right after only toggles if the second hit raised no pulse
        issue_read(`LC_BFM_RMA_ADDR);
        n    = 0;
        lows = 0;
        while ((m_cnt < `LC_BFM_HOLD || (|m_dly)) && n < 1000) begin
            drive(1'b0, 32'h0, 1'b1, lc_bfm_pkg::Off);
            lows += (sys_reset_n === 1'b0) ? 1 : 0;
            n++;
        end
        if (n >= 1000) begin
            errors++;
            $display("timeout: power sequencer never went idle");
        end
        if (lows != 0) begin
            errors++;
            $display("FAIL %0t: lost pulses held sys_reset_n low %0d cycles", $time, lows);
        end
        end_test("pwr_lost");

        // Taken pulse with its assertion delay and low length
        issue_read(`LC_BFM_PWR_ADDR);
        // First sample follows the handshake edge itself
        n = -1;
        while (sys_reset_n === 1'b1 && n < 64) begin
            drive(1'b0, 32'h0, 1'b1, lc_bfm_pkg::Off);
            n++;
        end
        if (n >= 64) begin
            errors++;
            $display("timeout: sys_reset_n never asserted after power read");
        end else if (n != `LC_BFM_DELAY + 2) begin
            errors++;
            $display("FAIL %0t: sys_reset_n low after %0d cycles, expected %0d", $time,
                     n, `LC_BFM_DELAY + 2);
        end
        lows = 1;
        while (sys_reset_n === 1'b0 && lows < `LC_BFM_HOLD + 50) begin
            drive(1'b0, 32'h0, 1'b1, lc_bfm_pkg::Off);
            lows += (sys_reset_n === 1'b0) ? 1 : 0;
        end
        if (lows != `LC_BFM_HOLD + 1) begin
            errors++;
            $display("FAIL %0t: sys_reset_n low %0d cycles, expected %0d", $time,
                     lows, `LC_BFM_HOLD + 1);
        end
        end_test("pwr_taken");

        // Three free toggles and one gated by a power pulse before a status read
        rma_start = rma_strap;
        repeat (3) begin
            issue_read(`LC_BFM_RMA_ADDR);
            drive(1'b0, 32'h0, 1'b1, lc_bfm_pkg::Off);
        end
        issue_read(`LC_BFM_PWR_ADDR);
        issue_read(`LC_BFM_RMA_ADDR);
        issue_read(`LC_BFM_STATUS_ADDR);
        drive(1'b0, 32'h0, 1'b1, lc_bfm_pkg::Off);
        check_level(rma_strap, !rma_start, "rma_strap after toggles");
        end_test("rma");

        repeat (2000) random_cycle(1'b1);
        end_test("read_rsp");

        repeat (300) random_cycle(1'b0);
        end_test("clk_byp");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        #200000;
        $display("watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/axi_rd_pkg.sv
design/lc_bfm_pkg.sv
design/axi_rd_target.sv
design/lc_trigger_decode.sv
design/lc_power_seq.sv
design/lc_clk_byp_resp.sv
design/lc_ctrl_bfm.sv
dv/lc_ctrl_bfm_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= lc_ctrl_bfm_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
